// ==== cam_edge_pkg.sv ====
`default_nettype none

package cam_edge_pkg;

  // rgb565 pixel and output word
  localparam int pix_w = 16;

  // line and pixel counters, the tag word carries the line count
  localparam int cnt_w = 16;

  // green level for the gradient
  // 6-bit g field in the upper bits, two zero bits below
  localparam int gray_w = 8;

  // filter output colours
  localparam logic [pix_w-1:0] edge_on  = '1;  // white, edge found
  localparam logic [pix_w-1:0] edge_off = '0;  // black, flat area

endpackage

`default_nettype wire

// ==== ov5640_capture.sv ====
`timescale 1ns/100ps
`default_nettype none

module ov5640_capture (
  input  wire                            ov5640_pclk,   // camera pixel clock
  input  wire                            sys_rst_n,     // async reset, low active
  input  wire                            ov5640_href,   // line valid from sensor
  input  wire                            ov5640_vsync,  // frame sync from sensor
  input  wire  [7:0]                     ov5640_data,   // byte bus, two per pixel
  output logic                           pix_valid,     // one-cycle pixel strobe
  output logic [cam_edge_pkg::pix_w-1:0] pix_data,      // rgb565, valid with pix_valid
  output logic                           line_start,    // href rise, one cycle late
  output logic                           line_end,      // href fall, one cycle late
  output logic                           frame_start    // vsync rise, one cycle late
);

  logic       href_d;      // href delayed one cycle
  logic       vsync_d;     // vsync delayed one cycle
  logic       byte_phase;  // high byte already held
  logic [7:0] hi_byte;     // first byte of the pair

  // sync edge detect, strobes registered
  always_ff @(posedge ov5640_pclk or negedge sys_rst_n) begin
    if (!sys_rst_n) begin
      href_d      <= 1'b0;
      vsync_d     <= 1'b0;
      line_start  <= 1'b0;
      line_end    <= 1'b0;
      frame_start <= 1'b0;
    end else begin
      href_d      <= ov5640_href;
      vsync_d     <= ov5640_vsync;
      line_start  <= ov5640_href & ~href_d;    // 0 -> 1
      line_end    <= ~ov5640_href & href_d;    // 1 -> 0
      frame_start <= ov5640_vsync & ~vsync_d;  // new frame
    end
  end

  // byte phase, restarts on every line
  always_ff @(posedge ov5640_pclk or negedge sys_rst_n) begin
    if (!sys_rst_n) begin
      byte_phase <= 1'b0;
      pix_valid  <= 1'b0;
    end else begin
      pix_valid <= ov5640_href & byte_phase;  // second byte seen
      if (!ov5640_href) begin
        byte_phase <= 1'b0;  // odd leftover byte dropped here
      end else begin
        byte_phase <= ~byte_phase;
      end
    end
  end

  // pair assembly, high byte comes first
  always_ff @(posedge ov5640_pclk) begin
    if (ov5640_href && !byte_phase) begin
      hi_byte <= ov5640_data;
    end
    if (ov5640_href && byte_phase) begin
      pix_data <= {hi_byte, ov5640_data};  // r5 g6 b5
    end
  end

  // two bytes per pixel, so strobes never touch
  a_pix_spacing : assert property (
    @(posedge ov5640_pclk) disable iff (!sys_rst_n)
    pix_valid |=> !pix_valid
  ) else $error("pix_valid high in two consecutive cycles");

endmodule

`default_nettype wire

// ==== row_gradient_edge.sv ====
`timescale 1ns/100ps
`default_nettype none

module row_gradient_edge (
  input  wire                            ov5640_pclk,     // pixel clock
  input  wire                            sys_rst_n,       // async reset, low active
  input  wire  [7:0]                     edge_threshold,  // static, strict compare
  input  wire                            pix_valid,       // pixel strobe from capture
  input  wire  [cam_edge_pkg::pix_w-1:0] pix_data,        // rgb565 in
  input  wire                            line_end,        // flush last pixel
  output logic                           edge_valid,      // result strobe
  output logic [cam_edge_pkg::pix_w-1:0] edge_data        // edge_on or edge_off
);

  logic [cam_edge_pkg::gray_w-1:0] cur_g;    // level of incoming pixel
  logic [cam_edge_pkg::gray_w-1:0] mid_g;    // pending pixel, previous one
  logic [cam_edge_pkg::gray_w-1:0] left_g;   // pixel before the pending one
  logic [cam_edge_pkg::gray_w-1:0] right_g;  // right neighbour of pending pixel
  logic [cam_edge_pkg::gray_w-1:0] diff_g;   // abs(left - right)
  logic                            first_in_line;  // nothing pending yet
  logic                            decide;   // pending pixel resolved this cycle
  logic                            is_edge;

  // green field into the top six bits
  assign cur_g = {pix_data[10:5], 2'b00};

  // at line end the last pixel is its own right neighbour
  assign right_g = pix_valid ? cur_g : mid_g;

  assign diff_g = (left_g > right_g) ? (left_g - right_g) : (right_g - left_g);

  assign is_edge = diff_g > edge_threshold;  // equal is not an edge

  // a new pixel or the line end closes the pending one
  assign decide = (pix_valid | line_end) & ~first_in_line;

  // control, reset
  always_ff @(posedge ov5640_pclk or negedge sys_rst_n) begin
    if (!sys_rst_n) begin
      first_in_line <= 1'b1;
      edge_valid    <= 1'b0;
    end else begin
      edge_valid <= decide;  // one cycle after pixel x+1
      if (line_end) begin
        first_in_line <= 1'b1;  // next line starts empty
      end else if (pix_valid) begin
        first_in_line <= 1'b0;
      end
    end
  end

  // level pipeline, one pixel deep
  always_ff @(posedge ov5640_pclk) begin
    if (pix_valid) begin
      mid_g  <= cur_g;
      left_g <= first_in_line ? cur_g : mid_g;  // first pixel mirrors left side
    end
  end

  // result word
  always_ff @(posedge ov5640_pclk) begin
    if (decide) begin
      edge_data <= is_edge ? cam_edge_pkg::edge_on : cam_edge_pkg::edge_off;
    end
  end

  // capture ends a line one cycle after its last pixel at the earliest
  a_no_overlap : assert property (
    @(posedge ov5640_pclk) disable iff (!sys_rst_n)
    !(pix_valid && line_end)
  ) else $error("pix_valid and line_end in the same cycle");

endmodule

`default_nettype wire

// ==== line_tagger.sv ====
`timescale 1ns/100ps
`default_nettype none

module line_tagger #(
  parameter int h_pixel = 640  // full line length in pixels
) (
  input  wire                            ov5640_pclk,   // pixel clock
  input  wire                            sys_rst_n,     // async reset, low active
  input  wire                            line_start,    // new line strobe
  input  wire                            frame_start,   // new frame strobe
  input  wire                            ov5640_vsync,  // holds line count at zero
  input  wire                            edge_valid,    // filtered pixel strobe
  input  wire  [cam_edge_pkg::pix_w-1:0] edge_data,     // filtered pixel
  output logic                           out_valid,     // word strobe to sender
  output logic [cam_edge_pkg::pix_w-1:0] out_data,      // pixel or line number
  output logic                           out_is_tag     // out_data is a line number
);

  logic [cam_edge_pkg::cnt_w-1:0] line_cnt;  // line number in frame, from 1
  logic [cam_edge_pkg::cnt_w-1:0] pix_cnt;   // edge words in this line
  logic                           cnt_eq;    // line just became full
  logic                           eq_d;      // cnt_eq one cycle back
  logic                           tag_fire;  // insert tag word now

  assign cnt_eq   = (pix_cnt == cam_edge_pkg::cnt_w'(h_pixel));
  assign tag_fire = cnt_eq & ~eq_d;  // once per line, extras ignored

  // line counter
  always_ff @(posedge ov5640_pclk or negedge sys_rst_n) begin
    if (!sys_rst_n) begin
      line_cnt <= '0;
    end else if (ov5640_vsync) begin
      line_cnt <= '0;  // held through the frame gap
    end else if (line_start) begin
      line_cnt <= line_cnt + 1'b1;
    end
  end

  // pixel counter
  always_ff @(posedge ov5640_pclk or negedge sys_rst_n) begin
    if (!sys_rst_n) begin
      pix_cnt <= '0;
    end else if (line_start || frame_start) begin
      pix_cnt <= '0;
    end else if (edge_valid) begin
      pix_cnt <= pix_cnt + 1'b1;
    end
  end

  // output strobes
  always_ff @(posedge ov5640_pclk or negedge sys_rst_n) begin
    if (!sys_rst_n) begin
      eq_d       <= 1'b0;
      out_valid  <= 1'b0;
      out_is_tag <= 1'b0;
    end else begin
      eq_d       <= cnt_eq;
      out_valid  <= edge_valid | tag_fire;
      out_is_tag <= tag_fire;  // cycle after last pixel word
    end
  end

  // output word
  always_ff @(posedge ov5640_pclk) begin
    if (tag_fire) begin
      out_data <= line_cnt;
    end else if (edge_valid) begin
      out_data <= edge_data;
    end
  end

  // filter leaves a gap after every word, the tag slot must be free
  a_tag_slot : assert property (
    @(posedge ov5640_pclk) disable iff (!sys_rst_n)
    tag_fire |-> !edge_valid
  ) else $error("edge word collides with line tag");

endmodule

`default_nettype wire

// ==== cam_edge_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module cam_edge_top #(
  parameter int h_pixel = 640  // pixels per full line
) (
  input  wire                            ov5640_pclk,     // camera pixel clock
  input  wire                            sys_rst_n,       // async reset, low active
  input  wire                            ov5640_href,
  input  wire                            ov5640_vsync,
  input  wire  [7:0]                     ov5640_data,
  input  wire  [7:0]                     edge_threshold,  // held static
  output logic                           out_valid,
  output logic [cam_edge_pkg::pix_w-1:0] out_data,
  output logic                           out_is_tag,
  output logic                           frame_start
);

  logic                           pix_valid;   // capture -> filter
  logic [cam_edge_pkg::pix_w-1:0] pix_data;
  logic                           line_end;
  logic                           line_start;  // capture -> tagger
  logic                           edge_valid;  // filter -> tagger
  logic [cam_edge_pkg::pix_w-1:0] edge_data;

  ov5640_capture u_capture (
    .ov5640_pclk  (ov5640_pclk),
    .sys_rst_n    (sys_rst_n),
    .ov5640_href  (ov5640_href),
    .ov5640_vsync (ov5640_vsync),
    .ov5640_data  (ov5640_data),
    .pix_valid    (pix_valid),
    .pix_data     (pix_data),
    .line_start   (line_start),
    .line_end     (line_end),
    .frame_start  (frame_start)  // also a top output
  );

  row_gradient_edge u_edge (
    .ov5640_pclk    (ov5640_pclk),
    .sys_rst_n      (sys_rst_n),
    .edge_threshold (edge_threshold),
    .pix_valid      (pix_valid),
    .pix_data       (pix_data),
    .line_end       (line_end),
    .edge_valid     (edge_valid),
    .edge_data      (edge_data)
  );

  line_tagger #(
    .h_pixel (h_pixel)
  ) u_tagger (
    .ov5640_pclk  (ov5640_pclk),
    .sys_rst_n    (sys_rst_n),
    .line_start   (line_start),
    .frame_start  (frame_start),
    .ov5640_vsync (ov5640_vsync),
    .edge_valid   (edge_valid),
    .edge_data    (edge_data),
    .out_valid    (out_valid),
    .out_data     (out_data),
    .out_is_tag   (out_is_tag)
  );

endmodule

`default_nettype wire

// ==== cam_edge_checker.sv ====
`timescale 1ns/100ps
`default_nettype none

module cam_edge_checker #(
  parameter int h_pixel = 16  // full line length, a tag follows
) (
  input  wire                            ov5640_pclk,
  input  wire                            sys_rst_n,
  input  wire                            ov5640_href,
  input  wire                            ov5640_vsync,
  input  wire  [7:0]                     ov5640_data,
  input  wire  [7:0]                     edge_threshold,
  input  wire                            out_valid,
  input  wire  [cam_edge_pkg::pix_w-1:0] out_data,
  input  wire                            out_is_tag,
  input  wire                            frame_start,
  input  wire                            run_done,     // stimulus finished
  output logic                           report_done,  // closing line printed
  output int                             err_count
);

  logic [cam_edge_pkg::pix_w-1:0] exp_data[$];  // reference words, in order
  logic                           exp_tag[$];
  logic [cam_edge_pkg::pix_w-1:0] act_data[$];  // words seen at out_valid
  logic                           act_tag[$];
  logic [cam_edge_pkg::pix_w-1:0] line_pix [0:63];  // pixels rebuilt from pins
  logic [cam_edge_pkg::pix_w-1:0] e_d;
  logic [cam_edge_pkg::pix_w-1:0] a_d;
  logic       e_t;
  logic       a_t;
  logic [7:0] hi_byte;              // first byte of a pair
  logic       have_hi     = 1'b0;
  logic       href_prev   = 1'b0;
  logic       vs_1        = 1'b0;   // vsync one sample back
  logic       vs_2        = 1'b0;   // two samples back
  logic       active_seen = 1'b0;   // first href or vsync seen
  logic       done_q      = 1'b0;
  int         n_pix       = 0;
  int         line_no     = 0;      // line number in frame
  int         data_errs   = 0;
  int         pin_errs    = 0;
  int         flow_errs   = 0;
  int         checked     = 0;

  assign err_count   = data_errs + pin_errs + flow_errs;
  assign report_done = done_q;

  // reference: neighbour green levels, strictly greater than threshold
  function automatic logic [cam_edge_pkg::pix_w-1:0] expect_edge(
    input logic [cam_edge_pkg::pix_w-1:0] left_pix,
    input logic [cam_edge_pkg::pix_w-1:0] right_pix,
    input logic [7:0]                     thr
  );
    int gl;
    int gr;
    int diff;
    gl   = int'(left_pix[10:5]) * 4;   // g6 scaled to 8 bits
    gr   = int'(right_pix[10:5]) * 4;
    diff = (gl > gr) ? gl - gr : gr - gl;
    if (diff > int'(thr)) begin
      return cam_edge_pkg::edge_on;
    end else begin
      return cam_edge_pkg::edge_off;
    end
  endfunction

  // queue the words one finished line must produce
  task automatic close_line();
    int x;
    int lx;
    int rx;
    for (x = 0; x < n_pix; x++) begin
      lx = (x == 0) ? 0 : x - 1;              // ends replicate themselves
      rx = (x == n_pix - 1) ? x : x + 1;
      exp_data.push_back(expect_edge(line_pix[lx], line_pix[rx], edge_threshold));
      exp_tag.push_back(1'b0);
    end
    if (n_pix == h_pixel) begin
      exp_data.push_back(line_no[cam_edge_pkg::pix_w-1:0]);  // line tag
      exp_tag.push_back(1'b1);
    end
    n_pix = 0;
  endtask

  task automatic pin_check(input string name, input logic expv, input logic actv);
    if (actv !== expv) begin
      pin_errs++;
      $display("ERR %s exp %h got %h at %0t", name, expv, actv, $time);
    end
  endtask

  always @(posedge ov5640_pclk) begin
    if (!active_seen) begin  // quiet outputs until camera starts
      pin_check("out_valid", 1'b0, out_valid);
      pin_check("out_is_tag", 1'b0, out_is_tag);
      active_seen = sys_rst_n & (ov5640_href | ov5640_vsync);
    end
    pin_check("frame_start", sys_rst_n & vs_1 & ~vs_2, frame_start);
    if (!sys_rst_n) begin
      vs_1      = 1'b0;
      vs_2      = 1'b0;
      href_prev = 1'b0;
      have_hi   = 1'b0;
      n_pix     = 0;
      line_no   = 0;
      done_q    = 1'b0;
    end else begin
      vs_2 = vs_1;
      vs_1 = ov5640_vsync;
      if (ov5640_vsync) begin
        line_no = 0;  // numbering restarts per frame
      end else if (ov5640_href && !href_prev) begin
        line_no++;
      end
      if (ov5640_href) begin
        if (!have_hi) begin
          hi_byte = ov5640_data;  // high byte first
          have_hi = 1'b1;
        end else begin
          if (n_pix < 64) begin
            line_pix[n_pix] = {hi_byte, ov5640_data};
          end
          n_pix++;
          have_hi = 1'b0;
        end
      end else begin
        have_hi = 1'b0;  // odd byte dropped
      end
      if (!ov5640_href && href_prev) begin
        close_line();
      end
      href_prev = ov5640_href;
      if (out_valid) begin
        act_data.push_back(out_data);
        act_tag.push_back(out_is_tag);
      end
      if (run_done && !done_q) begin
        if (exp_data.size() != 0) begin
          flow_errs++;
          $display("missing output: %0d expected words never came out", exp_data.size());
        end
        if (act_data.size() != 0) begin
          flow_errs++;
          $display("unexpected output: %0d extra words from the DUT", act_data.size());
        end
        if (checked == 0) begin
          flow_errs++;
          $display("no output words were compared");
        end
        $display("checked %0d words, errors: %0d data, %0d pin, %0d flow",
                 checked, data_errs, pin_errs, flow_errs);
        done_q = 1'b1;
      end
    end
  end

  // compare in order whenever both sides have a word
  always @(negedge ov5640_pclk) begin
    while (exp_data.size() > 0 && act_data.size() > 0) begin
      e_d = exp_data.pop_front();
      e_t = exp_tag.pop_front();
      a_d = act_data.pop_front();
      a_t = act_tag.pop_front();
      checked++;
      if (a_t !== e_t) begin
        data_errs++;
        $display("ERR out_is_tag exp %h got %h at %0t", e_t, a_t, $time);
      end
      if (a_d !== e_d) begin
        data_errs++;
        $display("ERR out_data exp %h got %h at %0t", e_d, a_d, $time);
      end
    end
  end

endmodule

`default_nettype wire

// ==== tb_cam_edge.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_cam_edge;

  localparam int h_pix    = 16;  // pixels in a full line
  localparam int n_frames = 3;
  localparam int n_lines  = 5;   // lines per frame
  localparam int max_gap  = 12;  // upper bound of href low cycles between lines
  localparam int vs_len   = 6;   // vsync high cycles and low cycles after
  localparam int stim_cycles =
    33 + n_frames * (2 * vs_len + n_lines * (2 * h_pix + 2 + max_gap));
  localparam int timeout_cycles = stim_cycles * 2 + 200;

  logic                           ov5640_pclk = 1'b0;
  logic                           sys_rst_n;
  logic                           ov5640_href;
  logic                           ov5640_vsync;
  logic [7:0]                     ov5640_data;
  logic [7:0]                     edge_threshold;
  logic                           run_done;
  wire                            out_valid;
  wire  [cam_edge_pkg::pix_w-1:0] out_data;
  wire                            out_is_tag;
  wire                            frame_start;
  wire                            report_done;
  int                             err_count;
  int                             cycle_cnt = 0;
  int                             f;
  int                             l;

  always #2 ov5640_pclk = ~ov5640_pclk;  // 4 ns period

  cam_edge_top #(.h_pixel(h_pix)) u_dut (
    .ov5640_pclk(ov5640_pclk), .sys_rst_n(sys_rst_n),
    .ov5640_href(ov5640_href), .ov5640_vsync(ov5640_vsync),
    .ov5640_data(ov5640_data), .edge_threshold(edge_threshold),
    .out_valid(out_valid), .out_data(out_data),
    .out_is_tag(out_is_tag), .frame_start(frame_start)
  );

  cam_edge_checker #(.h_pixel(h_pix)) u_chk (
    .ov5640_pclk(ov5640_pclk), .sys_rst_n(sys_rst_n),
    .ov5640_href(ov5640_href), .ov5640_vsync(ov5640_vsync),
    .ov5640_data(ov5640_data), .edge_threshold(edge_threshold),
    .out_valid(out_valid), .out_data(out_data),
    .out_is_tag(out_is_tag), .frame_start(frame_start),
    .run_done(run_done), .report_done(report_done), .err_count(err_count)
  );

  function automatic logic [7:0] thr_for_frame(input int fr);
    case (fr)
      0:       return 8'd0;    // any neighbour difference is an edge
      1:       return 8'd40;
      default: return 8'd255;  // above the largest level step
    endcase
  endfunction

  // frame 1 last line has green steps of exactly 40 and 44
  function automatic logic [15:0] make_pixel(input int fr, input int ln, input int x);
    logic [15:0] rnd;
    logic [5:0]  g6;
    rnd = 16'($urandom);
    g6  = (x % 4 >= 2) ? ((x < 8) ? 6'd10 : 6'd11) : 6'd0;
    if (fr == 1 && ln == n_lines - 1) begin
      return {rnd[15:11], g6, rnd[4:0]};
    end
    return rnd;
  endfunction

  task automatic idle(input int n);
    repeat (n) begin
      @(negedge ov5640_pclk);
      ov5640_href = 1'b0;
      ov5640_data = 8'h00;
    end
  endtask

  task automatic send_vsync(input logic [7:0] thr);
    @(negedge ov5640_pclk);
    ov5640_vsync   = 1'b1;
    edge_threshold = thr;  // pipeline idle here
    repeat (vs_len - 1) @(negedge ov5640_pclk);
    @(negedge ov5640_pclk);
    ov5640_vsync = 1'b0;
    repeat (vs_len - 1) @(negedge ov5640_pclk);
  endtask

  task automatic send_line(input int fr, input int ln, input int n_pix, input bit odd_byte);
    logic [15:0] p;
    int          x;
    for (x = 0; x < n_pix; x++) begin
      p = make_pixel(fr, ln, x);
      @(negedge ov5640_pclk);
      ov5640_href = 1'b1;
      ov5640_data = p[15:8];  // high byte first
      @(negedge ov5640_pclk);
      ov5640_data = p[7:0];
    end
    if (odd_byte) begin
      @(negedge ov5640_pclk);
      ov5640_data = 8'($urandom);  // dangling byte
    end
    @(negedge ov5640_pclk);
    ov5640_href = 1'b0;
    ov5640_data = 8'h00;
  endtask

  always @(posedge ov5640_pclk) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt >= timeout_cycles) begin
      $display("timeout: run did not end within %0d cycles", timeout_cycles);
      $display("Test FAILED");
      $finish;
    end
  end

  initial begin
    void'($urandom(84));
    sys_rst_n      = 1'b1;
    ov5640_href    = 1'b0;
    ov5640_vsync   = 1'b0;
    ov5640_data    = 8'h00;
    edge_threshold = 8'h00;
    run_done       = 1'b0;
    #1 sys_rst_n = 1'b0;
    repeat (3) @(negedge ov5640_pclk);
    sys_rst_n = 1'b1;
    idle(10);  // outputs must stay quiet
    for (f = 0; f < n_frames; f++) begin
      send_vsync(thr_for_frame(f));
      for (l = 0; l < n_lines; l++) begin
        send_line(f, l, (f == 0 && l == 2) ? 10 : h_pix, f == 0 && l == 1);
        idle(4 + int'($urandom % (max_gap - 3)));  // gap long enough for the tag
      end
    end
    idle(20);
    run_done = 1'b1;
    wait (report_done);
    @(negedge ov5640_pclk);
    if (err_count == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== cam_edge.f ====
cam_edge_pkg.sv
ov5640_capture.sv
row_gradient_edge.sv
line_tagger.sv
cam_edge_top.sv
cam_edge_checker.sv
tb_cam_edge.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  -f cam_edge.f --top-module tb_cam_edge \
  -Mdir obj_dir -o sim_cam_edge

status=0
./obj_dir/sim_cam_edge > sim.log 2>&1 || status=$?
cat sim.log

if grep -qx "Test OK" sim.log; then
  exit 0
fi
echo "simulation failed, exit status $status"
exit 1
